// ==== ex_unit.f ====
+incdir+sim
hw/alu_pkg.sv
hw/ex_pkg.sv
hw/mul_iter.sv
hw/div_radix2.sv
hw/alu_core.sv
hw/ex_commit.sv
hw/ex_unit.sv
sim/ex_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the ex_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
    --top-module ex_unit_tb -f ex_unit.f -o ex_unit_sim

# the simulator's exit status is not trusted here, the log decides
./obj_dir/ex_unit_sim 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi

if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

echo "simulation passed"

// ==== sim/ex_vectors.svh ====
`ifndef ex_vectors_svh
`define ex_vectors_svh

// each row is op, a, b, cp0_data, expected y, expected overflow
task automatic load_vectors();
    // hi/lo straight out of reset
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_add,   32'h7fffffff, 32'h00000001, 32'h0, 32'h80000000, 1'b1);
    add_row(alu_pkg::op_add,   32'h00000005, 32'hfffffffd, 32'h0, 32'h00000002, 1'b0);
    add_row(alu_pkg::op_add,   32'h80000000, 32'h80000000, 32'h0, 32'h00000000, 1'b1);
    add_row(alu_pkg::op_addu,  32'hffffffff, 32'h00000001, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_sub,   32'h80000000, 32'h00000001, 32'h0, 32'h7fffffff, 1'b1);
    add_row(alu_pkg::op_sub,   32'h00000003, 32'h00000005, 32'h0, 32'hfffffffe, 1'b0);
    add_row(alu_pkg::op_sub,   32'h7fffffff, 32'hffffffff, 32'h0, 32'h80000000, 1'b1);
    add_row(alu_pkg::op_subu,  32'h00000000, 32'h00000001, 32'h0, 32'hffffffff, 1'b0);
    // signed overflow on the unsigned forms sets no flag
    add_row(alu_pkg::op_addu,  32'h7fffffff, 32'h00000001, 32'h0, 32'h80000000, 1'b0);
    add_row(alu_pkg::op_subu,  32'h80000000, 32'h00000001, 32'h0, 32'h7fffffff, 1'b0);
    add_row(alu_pkg::op_slt,   32'hffffffff, 32'h00000001, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_slt,   32'h00000001, 32'hffffffff, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_sltu,  32'hffffffff, 32'h00000001, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_sltu,  32'h00000001, 32'hffffffff, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_slt,   32'h80000000, 32'h7fffffff, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_and,   32'hf0f0a5a5, 32'h0ff05a5a, 32'h0, 32'h00f00000, 1'b0);
    add_row(alu_pkg::op_or,    32'hf0f0a5a5, 32'h0ff05a5a, 32'h0, 32'hfff0ffff, 1'b0);
    add_row(alu_pkg::op_nor,   32'h12340000, 32'h0000abcd, 32'h0, 32'hedcb5432, 1'b0);
    add_row(alu_pkg::op_xor,   32'hffff0000, 32'h0f0f0f0f, 32'h0, 32'hf0f00f0f, 1'b0);
    add_row(alu_pkg::op_lui,   32'h00000000, 32'hdead1234, 32'h0, 32'h12340000, 1'b0);
    // shift amount from a[4:0], value in b
    add_row(alu_pkg::op_sll,   32'h00000004, 32'h80000001, 32'h0, 32'h00000010, 1'b0);
    add_row(alu_pkg::op_srl,   32'h00000004, 32'hf0000000, 32'h0, 32'h0f000000, 1'b0);
    add_row(alu_pkg::op_sra,   32'h00000004, 32'hf0000000, 32'h0, 32'hff000000, 1'b0);
    add_row(alu_pkg::op_sra,   32'h00000021, 32'h80000000, 32'h0, 32'hc0000000, 1'b0);
    add_row(alu_pkg::op_srl,   32'h0000001f, 32'h80000000, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_mfc0,  32'h00000005, 32'h00000006, 32'hcafef00d, 32'hcafef00d, 1'b0);
    // moves keep the other half
    add_row(alu_pkg::op_mtlo,  32'h11112222, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h11112222, 1'b0);
    add_row(alu_pkg::op_mthi,  32'h33334444, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h11112222, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h33334444, 1'b0);
    // -3 * 7
    add_row(alu_pkg::op_mult,  32'hfffffffd, 32'h00000007, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffff, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffeb, 1'b0);
    add_row(alu_pkg::op_multu, 32'hffffffff, 32'h00000002, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hfffffffe, 1'b0);
    add_row(alu_pkg::op_mult,  32'h80000000, 32'h80000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h40000000, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mult,  32'h00010000, 32'hffff0000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffff, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    // hi gets the remainder, lo the quotient
    add_row(alu_pkg::op_div,   32'hfffffff9, 32'h00000002, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffff, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hfffffffd, 1'b0);
    add_row(alu_pkg::op_divu,  32'hfffffff9, 32'h00000002, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h00000001, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'h7ffffffc, 1'b0);
    add_row(alu_pkg::op_div,   32'h00000064, 32'hfffffff9, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h00000002, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hfffffff2, 1'b0);
    // divide by zero
    add_row(alu_pkg::op_div,   32'hfffffff6, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'hfffffff6, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffff, 1'b0);
    add_row(alu_pkg::op_divu,  32'h12345678, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_mfhi,  32'h00000000, 32'h00000000, 32'h0, 32'h12345678, 1'b0);
    add_row(alu_pkg::op_mflo,  32'h00000000, 32'h00000000, 32'h0, 32'hffffffff, 1'b0);
    add_row(alu_pkg::op_nop,   32'h00000005, 32'h00000006, 32'h0, 32'h00000000, 1'b0);
    add_row(alu_pkg::op_addu,  32'h12345678, 32'h11111111, 32'h0, 32'h23456789, 1'b0);
endtask

`endif

// ==== sim/ex_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_unit_tb;

    typedef struct packed {
        alu_pkg::alu_op_e           op;
        logic [alu_pkg::data_w-1:0] a;
        logic [alu_pkg::data_w-1:0] b;
        logic [alu_pkg::data_w-1:0] cp0_data;
        logic [alu_pkg::data_w-1:0] exp_y;
        logic                       exp_ovf;
    } vec_t;

    logic            clk = 1'b0;
    logic            rst;
    ex_pkg::ex_req_t req;
    logic            stall;
    ex_pkg::ex_rsp_t rsp;

    vec_t            vectors[$];
    logic [15:0]     lfsr = 16'd44;
    ex_pkg::ex_rsp_t exp_rsp;
    int              exp_row = 0;
    logic            rsp_due = 1'b0;    // set on the accepting edge
    logic            monitor_on = 1'b0;
    int              errors = 0;
    int              cycle_cnt = 0;
    int              cycle_limit = 0;

    task automatic add_row(input alu_pkg::alu_op_e op,
                           input logic [alu_pkg::data_w-1:0] a,
                           input logic [alu_pkg::data_w-1:0] b,
                           input logic [alu_pkg::data_w-1:0] cp0_data,
                           input logic [alu_pkg::data_w-1:0] exp_y,
                           input logic exp_ovf);
        vectors.push_back('{op, a, b, cp0_data, exp_y, exp_ovf});
    endtask

    `include "ex_vectors.svh"

    ex_unit ex_unit_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .stall (stall),
        .rsp   (rsp)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int stall_len_for(input alu_pkg::alu_op_e op);
        case (op)
            alu_pkg::op_mult, alu_pkg::op_multu: return alu_pkg::mul_cycles;
            alu_pkg::op_div, alu_pkg::op_divu:   return alu_pkg::div_cycles;
            default:                             return 0;
        endcase
    endfunction

    task automatic stop_run();
        errors++;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input ex_pkg::ex_rsp_t got, input ex_pkg::ex_rsp_t exp, input int row);
        if (got.valid !== exp.valid) begin
            $display("MISMATCH row %0d rsp.valid got %h expected %h", row, got.valid, exp.valid);
            stop_run();
        end else if (got.y !== exp.y) begin
            $display("MISMATCH row %0d rsp.y got %h expected %h", row, got.y, exp.y);
            stop_run();
        end else if (got.overflow !== exp.overflow) begin
            $display("MISMATCH row %0d rsp.overflow got %h expected %h",
                     row, got.overflow, exp.overflow);
            stop_run();
        end
    endtask

    task automatic check_stall_len(input int got, input int exp, input int row);
        if (got != exp) begin
            $display("MISMATCH row %0d stall_len got %h expected %h", row, got, exp);
            stop_run();
        end
    endtask

    // half a cycle after the edge that registers rsp
    always @(negedge clk) begin
        if (monitor_on) begin
            if (rsp_due) begin
                rsp_due = 1'b0;
                check_rsp(rsp, exp_rsp, exp_row);
            end else if (rsp.valid !== 1'b0) begin
                $display("rsp.valid was high with no accepted request, last row %0d", exp_row);
                stop_run();
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin : stimulus
        vec_t       v;
        int         stall_cnt;
        logic [1:0] gap;

        rst = 1'b1;
        req = '0;
        load_vectors();
        cycle_limit = vectors.size() * (alu_pkg::div_cycles + 6) + 20;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        monitor_on = 1'b1;
        @(posedge clk);
        for (int i = 0; i < vectors.size(); i++) begin
            v = vectors[i];
            req <= '{valid: 1'b1, op: v.op, a: v.a, b: v.b, cp0_data: v.cp0_data};
            stall_cnt = 0;
            @(negedge clk);
            while (stall) begin // row stays put
                stall_cnt++;
                @(negedge clk);
            end
            check_stall_len(stall_cnt, stall_len_for(v.op), i);
            @(posedge clk);
            exp_rsp = '{valid: 1'b1, y: v.exp_y, overflow: v.exp_ovf};
            exp_row = i;
            rsp_due = 1'b1;
            gap[0] = lfsr[15];
            lfsr = lfsr_next(lfsr);
            gap[1] = lfsr[15];
            lfsr = lfsr_next(lfsr);
            if (gap != 2'd0 || i == vectors.size() - 1) begin
                req <= '0;
                repeat (gap) @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_unit (
    input  logic            clk,
    input  logic            rst,
    input  ex_pkg::ex_req_t req,
    output logic            stall,
    output ex_pkg::ex_rsp_t rsp
);

    ex_pkg::muldiv_req_t        mul_req;
    ex_pkg::muldiv_req_t        div_req;
    logic [alu_pkg::hilo_w-1:0] mul_result;
    logic                       mul_ready;
    logic [alu_pkg::hilo_w-1:0] div_result;
    logic                       div_ready;
    logic [alu_pkg::hilo_w-1:0] hilo;
    ex_pkg::ex_res_t            res;

    alu_core alu_core_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .hilo       (hilo),
        .mul_result (mul_result),
        .mul_ready  (mul_ready),
        .div_result (div_result),
        .div_ready  (div_ready),
        .mul_req    (mul_req),
        .div_req    (div_req),
        .stall      (stall),
        .res        (res)
    );

    mul_iter mul_iter_i (
        .clk    (clk),
        .rst    (rst),
        .req    (mul_req),
        .result (mul_result),
        .ready  (mul_ready)
    );

    div_radix2 div_radix2_i (
        .clk    (clk),
        .rst    (rst),
        .req    (div_req),
        .result (div_result),
        .ready  (div_ready)
    );

    ex_commit ex_commit_i (
        .clk  (clk),
        .rst  (rst),
        .res  (res),
        .hilo (hilo),
        .rsp  (rsp)
    );

endmodule

`default_nettype wire

// ==== hw/ex_commit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_commit (
    input  logic                       clk,
    input  logic                       rst,
    input  ex_pkg::ex_res_t            res,
    output logic [alu_pkg::hilo_w-1:0] hilo,
    output ex_pkg::ex_rsp_t            rsp
);

    logic [alu_pkg::data_w-1:0] hi;
    logic [alu_pkg::data_w-1:0] lo;
    logic                       hilo_wr;

    assign hilo_wr = res.valid && res.hilo_we;
    assign hilo    = {hi, lo};

    // mult/div result lands together with its response
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_wr) begin
            hi <= res.hilo_new[alu_pkg::hilo_w-1:alu_pkg::data_w];
            lo <= res.hilo_new[alu_pkg::data_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp.valid <= res.valid; // one cycle pulse per accepted request
            if (res.valid) begin
                rsp.y        <= res.y;
                rsp.overflow <= res.overflow;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_core (
    input  logic                       clk,
    input  logic                       rst,
    input  ex_pkg::ex_req_t            req,
    input  logic [alu_pkg::hilo_w-1:0] hilo,
    input  logic [alu_pkg::hilo_w-1:0] mul_result,
    input  logic                       mul_ready,
    input  logic [alu_pkg::hilo_w-1:0] div_result,
    input  logic                       div_ready,
    output ex_pkg::muldiv_req_t        mul_req,
    output ex_pkg::muldiv_req_t        div_req,
    output logic                       stall,
    output ex_pkg::ex_res_t            res
);

    logic [alu_pkg::data_w-1:0] sum;
    logic [alu_pkg::data_w-1:0] diff;
    logic                       is_mul;
    logic                       is_div;
    logic                       mul_signed;
    logic                       div_hit;

    // last divide, kept so a held divide is not run twice
    logic                       cache_valid;
    alu_pkg::alu_op_e           cache_op;
    logic [alu_pkg::data_w-1:0] cache_a;
    logic [alu_pkg::data_w-1:0] cache_b;
    logic [alu_pkg::hilo_w-1:0] cache_result;

    assign sum  = req.a + req.b;
    assign diff = req.a - req.b;

    assign is_mul = (req.op == alu_pkg::op_mult) || (req.op == alu_pkg::op_multu);
    assign is_div = (req.op == alu_pkg::op_div) || (req.op == alu_pkg::op_divu);
    assign mul_signed = (req.op == alu_pkg::op_mult);

    assign div_hit = cache_valid && !div_ready && (cache_op == req.op) &&
                     (cache_a == req.a) && (cache_b == req.b);

    // multiplier gets magnitudes, signed_op flags a negative product
    always_comb begin
        mul_req.start     = req.valid && is_mul && !mul_ready;
        mul_req.signed_op = mul_signed && (req.a[alu_pkg::sign_bit] ^ req.b[alu_pkg::sign_bit]);
        mul_req.a         = (mul_signed && req.a[alu_pkg::sign_bit]) ? -req.a : req.a;
        mul_req.b         = (mul_signed && req.b[alu_pkg::sign_bit]) ? -req.b : req.b;
    end

    always_comb begin
        div_req.start     = req.valid && is_div && !div_ready && !div_hit;
        div_req.signed_op = (req.op == alu_pkg::op_div);
        div_req.a         = req.a;
        div_req.b         = req.b;
    end

    assign stall = mul_req.start || div_req.start;

    always_comb begin
        res.valid    = req.valid && !stall;
        res.y        = '0;
        res.overflow = 1'b0;
        res.hilo_we  = 1'b0;
        res.hilo_new = hilo;
        case (req.op)
            alu_pkg::op_add: begin
                res.y        = sum;
                res.overflow = (req.a[alu_pkg::sign_bit] == req.b[alu_pkg::sign_bit]) &&
                               (sum[alu_pkg::sign_bit] != req.a[alu_pkg::sign_bit]);
            end
            alu_pkg::op_addu: res.y = sum;
            alu_pkg::op_sub: begin
                res.y        = diff;
                res.overflow = (req.a[alu_pkg::sign_bit] != req.b[alu_pkg::sign_bit]) &&
                               (diff[alu_pkg::sign_bit] != req.a[alu_pkg::sign_bit]);
            end
            alu_pkg::op_subu: res.y = diff;
            alu_pkg::op_slt:  res.y = {31'd0, $signed(req.a) < $signed(req.b)};
            alu_pkg::op_sltu: res.y = {31'd0, req.a < req.b};
            alu_pkg::op_and:  res.y = req.a & req.b;
            alu_pkg::op_or:   res.y = req.a | req.b;
            alu_pkg::op_nor:  res.y = ~(req.a | req.b);
            alu_pkg::op_xor:  res.y = req.a ^ req.b;
            alu_pkg::op_lui:  res.y = {req.b[15:0], 16'd0};
            alu_pkg::op_sll:  res.y = req.b << req.a[4:0]; // shift amount in a
            alu_pkg::op_srl:  res.y = req.b >> req.a[4:0];
            alu_pkg::op_sra:  res.y = $signed(req.b) >>> req.a[4:0];
            alu_pkg::op_mult,
            alu_pkg::op_multu: begin
                res.hilo_we  = 1'b1;
                res.hilo_new = mul_result;
            end
            alu_pkg::op_div,
            alu_pkg::op_divu: begin
                res.hilo_we  = 1'b1;
                res.hilo_new = div_ready ? div_result : cache_result;
            end
            alu_pkg::op_mthi: begin
                res.hilo_we  = 1'b1;
                res.hilo_new = {req.a, hilo[alu_pkg::data_w-1:0]};
            end
            alu_pkg::op_mtlo: begin
                res.hilo_we  = 1'b1;
                res.hilo_new = {hilo[alu_pkg::hilo_w-1:alu_pkg::data_w], req.a};
            end
            alu_pkg::op_mfhi: res.y = hilo[alu_pkg::hilo_w-1:alu_pkg::data_w];
            alu_pkg::op_mflo: res.y = hilo[alu_pkg::data_w-1:0];
            alu_pkg::op_mfc0: res.y = req.cp0_data;
            default:          res.y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_valid <= 1'b0;
        end else if (div_ready) begin
            cache_valid <= 1'b1;
        end
    end

    // request is still held while ready is up
    always_ff @(posedge clk) begin
        if (div_ready) begin
            cache_op     <= req.op;
            cache_a      <= req.a;
            cache_b      <= req.b;
            cache_result <= div_result;
        end
    end

endmodule

`default_nettype wire

// ==== hw/div_radix2.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_radix2 (
    input  logic                       clk,
    input  logic                       rst,
    input  ex_pkg::muldiv_req_t        req,
    output logic [alu_pkg::hilo_w-1:0] result,
    output logic                       ready
);

    typedef enum logic [1:0] {
        idle,
        busy,
        done
    } state_e;

    state_e                     state;
    logic [5:0]                 cnt;
    logic [alu_pkg::data_w-1:0] dsor;
    logic [alu_pkg::data_w-1:0] quo;
    logic [alu_pkg::data_w-1:0] rem;
    logic                       neg_q;
    logic                       neg_r;
    logic [alu_pkg::data_w-1:0] a_mag;
    logic [alu_pkg::data_w-1:0] b_mag;
    logic [alu_pkg::data_w:0]   rem_sh;
    logic [alu_pkg::data_w:0]   trial;

    assign a_mag = (req.signed_op && req.a[alu_pkg::sign_bit]) ? -req.a : req.a;
    assign b_mag = (req.signed_op && req.b[alu_pkg::sign_bit]) ? -req.b : req.b;

    // next dividend bit comes off the top of quo
    assign rem_sh = {rem, quo[alu_pkg::sign_bit]};
    assign trial  = rem_sh - {1'b0, dsor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            ready <= 1'b0;
            cnt   <= '0;
        end else begin
            ready <= 1'b0;
            case (state)
                idle: begin
                    if (req.start) begin
                        state <= busy;
                        cnt   <= '0;
                    end
                end
                busy: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'(alu_pkg::div_cycles - 3))
                        state <= done;
                end
                done: begin
                    state <= idle;
                    ready <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (req.start) begin
                    quo   <= a_mag;
                    rem   <= '0;
                    dsor  <= b_mag;
                    // divide by zero keeps an all-ones quotient
                    neg_q <= req.signed_op && (|req.b) &&
                             (req.a[alu_pkg::sign_bit] ^ req.b[alu_pkg::sign_bit]);
                    neg_r <= req.signed_op && req.a[alu_pkg::sign_bit];
                end
            end
            busy: begin
                quo <= {quo[alu_pkg::sign_bit-1:0], !trial[alu_pkg::data_w]};
                if (!trial[alu_pkg::data_w])
                    rem <= trial[alu_pkg::data_w-1:0];
                else
                    rem <= rem_sh[alu_pkg::data_w-1:0]; // restore
            end
            done: result <= {neg_r ? -rem : rem, neg_q ? -quo : quo};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/mul_iter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_iter (
    input  logic                       clk,
    input  logic                       rst,
    input  ex_pkg::muldiv_req_t        req,
    output logic [alu_pkg::hilo_w-1:0] result,
    output logic                       ready
);

    logic                       busy;
    logic [5:0]                 cnt;
    logic [alu_pkg::hilo_w-1:0] acc;
    logic [alu_pkg::hilo_w-1:0] mcand;
    logic [alu_pkg::data_w-1:0] mplier;
    logic                       neg;
    logic [alu_pkg::hilo_w-1:0] acc_next;

    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            ready <= 1'b0;
            cnt   <= '0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (req.start) begin
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end else begin
                cnt <= cnt + 6'd1;
                if (cnt == 6'(alu_pkg::mul_cycles - 2)) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req.start) begin
            acc    <= '0;
            mcand  <= {{alu_pkg::data_w{1'b0}}, req.a};
            mplier <= req.b;
            neg    <= req.signed_op;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (cnt == 6'(alu_pkg::mul_cycles - 2))
                result <= neg ? -acc_next : acc_next; // sign fix-up on last step
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef struct packed {
        logic                       valid;
        alu_pkg::alu_op_e           op;
        logic [alu_pkg::data_w-1:0] a;
        logic [alu_pkg::data_w-1:0] b;
        logic [alu_pkg::data_w-1:0] cp0_data;
    } ex_req_t;

    // core to commit
    typedef struct packed {
        logic                       valid;
        logic [alu_pkg::data_w-1:0] y;
        logic                       overflow;
        logic                       hilo_we;
        logic [alu_pkg::hilo_w-1:0] hilo_new;
    } ex_res_t;

    typedef struct packed {
        logic                       valid;
        logic [alu_pkg::data_w-1:0] y;
        logic                       overflow;
    } ex_rsp_t;

    typedef struct packed {
        logic                       start;
        logic                       signed_op;
        logic [alu_pkg::data_w-1:0] a;
        logic [alu_pkg::data_w-1:0] b;
    } muldiv_req_t;

endpackage

`default_nettype wire

// ==== hw/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int data_w   = 32;
    localparam int hilo_w   = 2 * data_w;
    localparam int sign_bit = data_w - 1;

    // start to ready, in cycles
    localparam int mul_cycles = 33;
    localparam int div_cycles = 34;

    typedef enum logic [4:0] {
        op_nop,
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_lui,
        op_sll,
        op_srl,
        op_sra,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mthi,
        op_mtlo,
        op_mfhi,
        op_mflo,
        op_mfc0
    } alu_op_e;

endpackage

`default_nettype wire
